// File: compile.f
+incdir+rtl
rtl/rpc_pkg.sv
rtl/rpc_cmd_decoder.sv
rtl/rpc_timing_fsm.sv
rtl/rpc_pad_ctrl.sv
rtl/rpc_timing_top.sv
verification/tb_clk_gen.sv
verification/tb_rpc_timing.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the RPC DRAM timing testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing -f compile.f --top-module tb_rpc_timing -o sim_tb \
  > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { echo "Verilator build or run error, see build.log and sim.log"; exit 1; }
grep -q "All tests passed" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

// File: verification/tb_rpc_timing.sv
// Directed testbench for the RPC DRAM command timing controller
`timescale 1ns/100ps
`default_nettype none

`include "rpc_settings.svh"

module tb_rpc_timing;

  import rpc_pkg::*;

  // Worst-case cycles per command, write bursts capped at 16 words
  localparam int ONE_SHOT_CYC = 16 + `RPC_N_CS_SU_HO + `RPC_N_WPST + `RPC_N_MOD + 4;
  localparam int WRITE_CYC    = ONE_SHOT_CYC + `RPC_N_WR_WAIT_CL + 3 + 8 * 16
                                + `RPC_N_WR_WPST + `RPC_N_WR_BESL;
  localparam int RUN_CYC      = 10 + 6 * ONE_SHOT_CYC + 2 * WRITE_CYC;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      cmd_valid_i;
  logic                      cmd_ready_o;
  logic [`RPC_CMD_WIDTH-1:0] cmd_i;
  logic                      cs_no;
  logic                      stb_o;
  logic                      dqs_cg_en_o;
  logic                      dqs_pair_oe_o;
  logic                      db_oe_o;
  rpc_db_src_e               db_src_o;
  logic                      mask_sel_o;
  logic [2:0]                data_sel_o;
  logic                      data_ready_o;

  integer seed;
  int     cyc;
  int     errors;
  int     n_tests;
  int     n_bad;
  int     bl;

  // Edge and beat logs, cycle numbers counted from reset release
  int stb_fall_q[$];
  int stb_rise_q[$];
  int rdy_rise_q[$];
  int cs_rise_q[$];
  int dr_q[$];
  int db_cyc_q[$];
  int db_src_q[$];
  int mask_q[$];
  int sel_q[$];
  logic stb_prev = 1'b1;
  logic rdy_prev = 1'b1;
  logic cs_prev  = 1'b1;

  tb_clk_gen u_clk_gen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  rpc_timing_top u_dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_ready_o   (cmd_ready_o),
    .cmd_i         (cmd_i),
    .cs_no         (cs_no),
    .stb_o         (stb_o),
    .dqs_cg_en_o   (dqs_cg_en_o),
    .dqs_pair_oe_o (dqs_pair_oe_o),
    .db_oe_o       (db_oe_o),
    .db_src_o      (db_src_o),
    .mask_sel_o    (mask_sel_o),
    .data_sel_o    (data_sel_o),
    .data_ready_o  (data_ready_o)
  );

  ////////////////////////////////////////////////////////////
  // Cycle counter and monitors
  ////////////////////////////////////////////////////////////

  // Tracks the tPPD divider phase, both start at zero on reset release
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) cyc <= 0;
    else cyc <= cyc + 1;
  end

  // Outputs settle well before the falling edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (stb_prev && !stb_o) stb_fall_q.push_back(cyc);
      if (!stb_prev && stb_o) stb_rise_q.push_back(cyc);
      if (!rdy_prev && cmd_ready_o) rdy_rise_q.push_back(cyc);
      if (!cs_prev && cs_no) cs_rise_q.push_back(cyc);
      if (data_ready_o) dr_q.push_back(cyc);
      // Every driven DB beat with its source and selects
      if (db_oe_o) begin
        db_cyc_q.push_back(cyc);
        db_src_q.push_back(int'(db_src_o));
        mask_q.push_back(int'(mask_sel_o));
        sel_q.push_back(int'(data_sel_o));
      end
    end
    stb_prev = stb_o;
    rdy_prev = cmd_ready_o;
    cs_prev  = cs_no;
  end

  ////////////////////////////////////////////////////////////
  // Helper tasks
  ////////////////////////////////////////////////////////////

  task automatic check(input int got, input int exp, input string msg);
    if (got !== exp) begin
      $display("[FAIL] %0t: %s, got %0d, expected %0d", $time, msg, got, exp);
      errors++;
    end
  endtask

  task automatic clear_logs();
    stb_fall_q.delete();
    stb_rise_q.delete();
    rdy_rise_q.delete();
    cs_rise_q.delete();
    dr_q.delete();
    db_cyc_q.delete();
    db_src_q.delete();
    mask_q.delete();
    sel_q.delete();
  endtask

  // Command word with random filler around the opcode and burst fields
  task automatic issue_cmd(input logic [3:0] opc, input int burst);
    logic [`RPC_CMD_WIDTH-1:0] w;
    w = $random(seed);
    w[`RPC_OPC_LSB +: `RPC_OPC_WIDTH] = opc;
    w[`RPC_BL_LSB +: `RPC_BL_WIDTH]   = burst[`RPC_BL_WIDTH-1:0];
    @(posedge clk_i);
    cmd_valid_i <= 1'b1;
    cmd_i       <= w;
    @(negedge clk_i);
    while (!cmd_ready_o) @(negedge clk_i);
    // Accept edge; cmd_i stays put for the decoder
    @(posedge clk_i);
    cmd_valid_i <= 1'b0;
  endtask

  task automatic wait_ready();
    @(negedge clk_i);
    while (!cmd_ready_o) @(negedge clk_i);
    // Monitors have logged the ready cycle by the next falling edge
    @(negedge clk_i);
  endtask

  task automatic report_test(input string name, input int e0);
    n_tests++;
    if (errors == e0) begin
      $display("Test %s: ok", name);
    end else begin
      n_bad++;
      $display("Test %s: %0d mismatches", name, errors - e0);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic reset_test();
    int e0;
    e0 = errors;
    wait (rst_ni === 1'b1);
    @(negedge clk_i);
    check(int'(cmd_ready_o), 1, "ready after reset");
    check(int'(cs_no), 1, "CS after reset");
    check(int'(stb_o), 1, "STB after reset");
    check(int'(db_oe_o), 0, "DB enable after reset");
    check(int'(dqs_pair_oe_o), 0, "DQS enable after reset");
    check(int'(dqs_cg_en_o), 0, "DQS clock gate after reset");
    check(int'(data_ready_o), 0, "word request after reset");
    report_test("reset_state", e0);
  endtask

  // ACT, PRE and MRS share the packet shape, only the wait differs
  task automatic one_shot_test(input logic [3:0] opc, input int n_wait, input string name);
    int e0;
    e0 = errors;
    clear_logs();
    issue_cmd(opc, 0);
    wait_ready();
    check(stb_fall_q.size(), 1, "STB pulse count");
    check(stb_rise_q[0] - stb_fall_q[0], 2, "STB low width");
    check(stb_fall_q[0] % 8, 1, "STB off the tPPD grid");
    check(db_cyc_q.size(), 1, "command beat count");
    check(db_src_q[0], int'(SRC_CMD), "command beat source");
    check(db_cyc_q[0] - stb_fall_q[0], 2, "command beat position");
    check(rdy_rise_q.size(), 1, "ready rise count");
    check(rdy_rise_q[0] - db_cyc_q[0], `RPC_N_WPST + n_wait, "ready delay");
    check(cs_rise_q.size(), 0, "CS released early");
    report_test(name, e0);
  endtask

  // Two commands back to back from WAIT_NEW_CMD
  task automatic tppd_test();
    int e0;
    e0 = errors;
    clear_logs();
    issue_cmd(OPC_ACT, 0);
    wait_ready();
    issue_cmd(OPC_ACT, 0);
    wait_ready();
    check(stb_fall_q.size(), 2, "STB pulse count");
    foreach (stb_fall_q[k]) check(stb_fall_q[k] % 8, 1, "STB off the tPPD grid");
    check(cs_rise_q.size(), 0, "CS released between commands");
    report_test("tppd_grid", e0);
  endtask

  task automatic write_test(input int burst);
    int e0;
    int nb;
    int last;
    e0 = errors;
    nb = 8 * (burst + 1);
    clear_logs();
    issue_cmd(OPC_WR, burst);
    wait_ready();
    check(db_cyc_q.size(), 3 + nb, "DB beat count");
    check(db_src_q[0], int'(SRC_CMD), "command beat source");
    // Postamble, CL wait and preamble before the mask beats
    check(db_cyc_q[1] - db_cyc_q[0], `RPC_N_WPST + `RPC_N_WR_WAIT_CL + 2, "mask start");
    check(db_cyc_q[2] - db_cyc_q[1], 1, "mask beats apart");
    check(db_src_q[1], int'(SRC_MASK), "first mask source");
    check(db_src_q[2], int'(SRC_MASK), "second mask source");
    check(mask_q[1], 1, "first mask select");
    check(mask_q[2], 0, "second mask select");
    for (int i = 3; i < db_cyc_q.size(); i++) begin
      check(db_cyc_q[i] - db_cyc_q[2], i - 2, "data beat cycle");
      check(db_src_q[i], int'(SRC_DATA), "data beat source");
      check(sel_q[i], 7 - ((i - 3) % 8), "data beat select");
    end
    // One request per word, on the beat with select 1
    check(dr_q.size(), burst + 1, "word request count");
    foreach (dr_q[k]) check(dr_q[k] - db_cyc_q[2], 8 * k + 7, "word request beat");
    last = db_cyc_q[db_cyc_q.size() - 1];
    check(rdy_rise_q[0] - last, `RPC_N_WR_WPST + `RPC_N_WR_BESL, "ready after write");
    report_test($sformatf("write_bl%0d", burst), e0);
  endtask

  task automatic illegal_test();
    int e0;
    e0 = errors;
    clear_logs();
    issue_cmd(4'hf, 0);
    wait_ready();
    check(db_cyc_q.size(), 1, "command beat count");
    check(cs_rise_q.size(), 1, "CS release count");
    check(cs_rise_q[0] - db_cyc_q[0], `RPC_N_WPST + 1, "CS release cycle");
    check(int'(cs_no), 1, "CS back high");
    check(rdy_rise_q[0] - db_cyc_q[0], `RPC_N_WPST + 1, "ready back high");
    report_test("illegal_opcode", e0);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    cmd_valid_i <= 1'b0;
    cmd_i       <= '0;
    seed    = 32'h3fe13bb1;
    errors  = 0;
    n_tests = 0;
    n_bad   = 0;
    reset_test();
    one_shot_test(OPC_ACT, `RPC_N_RCD, "act_one_shot");
    tppd_test();
    one_shot_test(OPC_PRE, `RPC_N_PRE, "pre_wait");
    one_shot_test(OPC_MRS, `RPC_N_MOD, "mrs_wait");
    repeat (2) begin
      bl = $random(seed) & 15;
      write_test(bl);
    end
    illegal_test();
    $display("Summary: %0d tests, %0d with errors, %0d mismatches", n_tests, n_bad, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Twice the worst-case run length
  initial begin
    #(2 * RUN_CYC * 10);
    $display("Timeout: the DUT did not finish the test sequence in time");
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/tb_clk_gen.sv
// Testbench clock source and power-on reset for the RPC DRAM timing controller
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS  = 10,
  parameter int RST_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_no
);

  // Free-running clock
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset held low for a fixed number of cycles, released on a rising edge
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

// File: rtl/rpc_timing_top.sv
// RPC DRAM command timing controller top level
`timescale 1ns/100ps
`default_nettype none

`include "rpc_settings.svh"

module rpc_timing_top (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  // Command handshake from upstream
  input  wire logic                      cmd_valid_i,
  output logic                           cmd_ready_o,
  input  wire logic [`RPC_CMD_WIDTH-1:0] cmd_i,
  // DRAM pad controls
  output logic                           cs_no,
  output logic                           stb_o,
  output logic                           dqs_cg_en_o,
  output logic                           dqs_pair_oe_o,
  output logic                           db_oe_o,
  // PHY datapath selects
  output rpc_pkg::rpc_db_src_e           db_src_o,
  output logic                           mask_sel_o,
  output logic [2:0]                     data_sel_o,
  output logic                           data_ready_o
);

  import rpc_pkg::*;

  rpc_opcode_e                opcode;
  logic [`RPC_BL_WIDTH-1:0]   burst_len;
  rpc_state_e                 state;
  logic [`RPC_CNT_WIDTH-1:0]  cnt;

  // Combinational field split
  rpc_cmd_decoder u_decoder (
    .cmd_i       (cmd_i),
    .opcode_o    (opcode),
    .burst_len_o (burst_len)
  );

  // Sequencer
  rpc_timing_fsm u_fsm (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_o (cmd_ready_o),
    .opcode_i    (opcode),
    .burst_len_i (burst_len),
    .state_o     (state),
    .cnt_o       (cnt)
  );

  // Pad and mux decode
  rpc_pad_ctrl u_pad (
    .state_i       (state),
    .cnt_i         (cnt),
    .cs_no         (cs_no),
    .stb_o         (stb_o),
    .dqs_cg_en_o   (dqs_cg_en_o),
    .dqs_pair_oe_o (dqs_pair_oe_o),
    .db_oe_o       (db_oe_o),
    .db_src_o      (db_src_o),
    .mask_sel_o    (mask_sel_o),
    .data_sel_o    (data_sel_o),
    .data_ready_o  (data_ready_o)
  );

endmodule

`default_nettype wire

// File: rtl/rpc_pad_ctrl.sv
// Pad enable, DB source and word request decoder for the RPC DRAM sequencer
`timescale 1ns/100ps
`default_nettype none

`include "rpc_settings.svh"

module rpc_pad_ctrl (
  // Sequencer status
  input  rpc_pkg::rpc_state_e             state_i,
  input  wire logic [`RPC_CNT_WIDTH-1:0]  cnt_i,
  // DRAM pad controls
  output logic                            cs_no,
  output logic                            stb_o,
  output logic                            dqs_cg_en_o,
  output logic                            dqs_pair_oe_o,
  output logic                            db_oe_o,
  // DB bus mux
  output rpc_pkg::rpc_db_src_e            db_src_o,
  output logic                            mask_sel_o,
  output logic [2:0]                      data_sel_o,
  // Word request to upstream, single-cycle strobe
  output logic                            data_ready_o
);

  import rpc_pkg::*;

  always_comb begin
    // Everything released by default
    cs_no         = 1'b1;
    stb_o         = 1'b1;
    dqs_cg_en_o   = 1'b0;
    dqs_pair_oe_o = 1'b0;
    db_oe_o       = 1'b0;
    db_src_o      = SRC_CMD;
    mask_sel_o    = 1'b0;
    data_sel_o    = 3'b000;
    data_ready_o  = 1'b0;

    // CS low for any active sequence
    if (state_i != IDLE) cs_no = 1'b0;

    case (state_i)
      // STB low for two cycles, DQS preamble on the second
      CMD_EN_STB: begin
        stb_o = 1'b0;
      end
      CMD_EN_DQS: begin
        stb_o         = 1'b0;
        dqs_cg_en_o   = 1'b1;
        dqs_pair_oe_o = 1'b1;
      end
      // Command beat
      CMD_SEND_DB: begin
        dqs_cg_en_o   = 1'b1;
        dqs_pair_oe_o = 1'b1;
        db_oe_o       = 1'b1;
        db_src_o      = SRC_CMD;
      end
      // Postambles hold DQS driven with the clock gated off
      CMD_ALIGN_WPST, WR_ALIGN_WPST: begin
        dqs_pair_oe_o = 1'b1;
      end
      WR_EN_DQS: begin
        dqs_cg_en_o   = 1'b1;
        dqs_pair_oe_o = 1'b1;
      end
      // First word mask on count 1, last word mask on count 0
      WR_MASK: begin
        dqs_cg_en_o   = 1'b1;
        dqs_pair_oe_o = 1'b1;
        db_oe_o       = 1'b1;
        db_src_o      = SRC_MASK;
        mask_sel_o    = cnt_i[0];
      end
      WR_DATA: begin
        dqs_cg_en_o   = 1'b1;
        dqs_pair_oe_o = 1'b1;
        db_oe_o       = 1'b1;
        db_src_o      = SRC_DATA;
        data_sel_o    = cnt_i[2:0];
        // Ask for next word one beat before the current one ends
        data_ready_o  = (cnt_i[2:0] == 3'd1);
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/rpc_timing_fsm.sv
// RPC DRAM command sequencer with wait counter, tPPD grid and command handshake
`timescale 1ns/100ps
`default_nettype none

`include "rpc_settings.svh"

module rpc_timing_fsm (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  // Command handshake
  input  wire logic                      cmd_valid_i,
  output logic                           cmd_ready_o,
  // Decoded command fields
  input  rpc_pkg::rpc_opcode_e           opcode_i,
  input  wire logic [`RPC_BL_WIDTH-1:0]  burst_len_i,
  // Sequencer status to pad control
  output rpc_pkg::rpc_state_e            state_o,
  output logic [`RPC_CNT_WIDTH-1:0]      cnt_o
);

  import rpc_pkg::*;

  // Counter reload values, each one less than the wait length
  localparam logic [`RPC_CNT_WIDTH-1:0] CNT_CS_SU_HO = `RPC_CNT_WIDTH'(`RPC_N_CS_SU_HO - 1);
  localparam logic [`RPC_CNT_WIDTH-1:0] CNT_WPST     = `RPC_CNT_WIDTH'(`RPC_N_WPST - 1);
  localparam logic [`RPC_CNT_WIDTH-1:0] CNT_RCD      = `RPC_CNT_WIDTH'(`RPC_N_RCD - 1);
  localparam logic [`RPC_CNT_WIDTH-1:0] CNT_PRE      = `RPC_CNT_WIDTH'(`RPC_N_PRE - 1);
  localparam logic [`RPC_CNT_WIDTH-1:0] CNT_MOD      = `RPC_CNT_WIDTH'(`RPC_N_MOD - 1);
  localparam logic [`RPC_CNT_WIDTH-1:0] CNT_WAIT_CL  = `RPC_CNT_WIDTH'(`RPC_N_WR_WAIT_CL - 1);
  localparam logic [`RPC_CNT_WIDTH-1:0] CNT_WR_WPST  = `RPC_CNT_WIDTH'(`RPC_N_WR_WPST - 1);
  localparam logic [`RPC_CNT_WIDTH-1:0] CNT_WR_BESL  = `RPC_CNT_WIDTH'(`RPC_N_WR_BESL - 1);
  // Zero padding above the beat count of a burst
  localparam int BURST_PAD = `RPC_CNT_WIDTH - `RPC_BL_WIDTH - 3;

  rpc_state_e                  state_q, state_d;
  logic [`RPC_CNT_WIDTH-1:0]   cnt_q, cnt_d;
  logic [`RPC_TPPD_WIDTH-1:0]  tppd_q;
  logic                        cnt_zero;
  logic                        cmd_take;

  assign cnt_zero = (cnt_q == '0);
  assign cmd_take = cmd_valid_i && cmd_ready_o;

  // Ready while idle, or once the previous command has completed
  assign cmd_ready_o = (state_q == IDLE) || ((state_q == WAIT_NEW_CMD) && cnt_zero);

  ////////////////////////////////////////////////////////////
  // Next state and counter
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    // Count down by default, a reload overrides
    cnt_d   = cnt_zero ? cnt_q : cnt_q - 1'b1;

    case (state_q)
      IDLE: begin
        if (cmd_take) begin
          state_d = CMD_EN_CS;
          cnt_d   = CNT_CS_SU_HO;
        end
      end
      // CS setup before the packet
      CMD_EN_CS: begin
        if (cnt_zero) state_d = CMD_ALIGN_TPPD;
      end
      // Hold until the parallel packet grid comes round
      CMD_ALIGN_TPPD: begin
        if (tppd_q == '0) state_d = CMD_EN_STB;
      end
      CMD_EN_STB: begin
        state_d = CMD_EN_DQS;
      end
      CMD_EN_DQS: begin
        state_d = CMD_SEND_DB;
      end
      CMD_SEND_DB: begin
        state_d = CMD_ALIGN_WPST;
        cnt_d   = CNT_WPST;
      end
      // After postamble, branch on opcode
      CMD_ALIGN_WPST: begin
        if (cnt_zero) begin
          case (opcode_i)
            OPC_ACT: begin
              state_d = WAIT_NEW_CMD;
              cnt_d   = CNT_RCD;
            end
            OPC_PRE: begin
              state_d = WAIT_NEW_CMD;
              cnt_d   = CNT_PRE;
            end
            OPC_MRS: begin
              state_d = WAIT_NEW_CMD;
              cnt_d   = CNT_MOD;
            end
            OPC_WR: begin
              state_d = WR_WAIT_CL;
              cnt_d   = CNT_WAIT_CL;
            end
            // Unknown command, release the bus
            default: state_d = IDLE;
          endcase
        end
      end
      // CS stays low; next command skips setup
      WAIT_NEW_CMD: begin
        if (cmd_take) state_d = CMD_ALIGN_TPPD;
      end
      // Write latency
      WR_WAIT_CL: begin
        if (cnt_zero) state_d = WR_EN_DQS;
      end
      // DQS preamble, then two mask beats
      WR_EN_DQS: begin
        state_d = WR_MASK;
        cnt_d   = `RPC_CNT_WIDTH'(1);
      end
      WR_MASK: begin
        if (cnt_zero) begin
          state_d = WR_DATA;
          // Eight beats per word, low bits select the beat
          cnt_d   = {{BURST_PAD{1'b0}}, burst_len_i, 3'b111};
        end
      end
      WR_DATA: begin
        if (cnt_zero) begin
          state_d = WR_ALIGN_WPST;
          cnt_d   = CNT_WR_WPST;
        end
      end
      WR_ALIGN_WPST: begin
        if (cnt_zero) begin
          state_d = WAIT_NEW_CMD;
          // Bus turnaround before accepting another command
          cnt_d   = CNT_WR_BESL;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      tppd_q  <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      // Free-running divider, wraps every eight cycles
      tppd_q  <= tppd_q + 1'b1;
    end
  end

  assign state_o = state_q;
  assign cnt_o   = cnt_q;

endmodule

`default_nettype wire

// File: rtl/rpc_cmd_decoder.sv
// Command word field decoder for the RPC DRAM command timing controller
`timescale 1ns/100ps
`default_nettype none

`include "rpc_settings.svh"

module rpc_cmd_decoder (
  // Raw command word, held stable by upstream for the whole sequence
  input  wire logic [`RPC_CMD_WIDTH-1:0] cmd_i,
  // Decoded fields
  output rpc_pkg::rpc_opcode_e           opcode_o,
  output logic [`RPC_BL_WIDTH-1:0]       burst_len_o
);

  import rpc_pkg::*;

  ////////////////////////////////////////////////////////////
  // Field extraction
  ////////////////////////////////////////////////////////////

  logic [`RPC_OPC_WIDTH-1:0] opc_field;
  logic [`RPC_BL_WIDTH-1:0]  bl_field;

  // Opcode sits in the low nibble
  assign opc_field = cmd_i[`RPC_OPC_LSB +: `RPC_OPC_WIDTH];

  // Burst count of words minus one
  assign bl_field = cmd_i[`RPC_BL_LSB +: `RPC_BL_WIDTH];

  // Cast to opcode type
  // Illegal codes pass through unchanged, sequencer rejects them
  assign opcode_o = rpc_opcode_e'(opc_field);

  // Burst length only matters for writes
  assign burst_len_o = bl_field;

endmodule

`default_nettype wire

// File: rtl/rpc_pkg.sv
// RPC DRAM PHY shared opcode, sequencer state and DB source types
`default_nettype none

`include "rpc_settings.svh"

package rpc_pkg;

  // DRAM command opcodes, any other code is illegal
  typedef enum logic [`RPC_OPC_WIDTH-1:0] {
    OPC_ACT = 4'd1,
    OPC_PRE = 4'd2,
    OPC_MRS = 4'd3,
    OPC_WR  = 4'd4
  } rpc_opcode_e;

  // Sequencer states
  typedef enum logic [4:0] {
    IDLE,
    // Parallel command packet
    CMD_EN_CS,
    CMD_ALIGN_TPPD,
    CMD_EN_STB,
    CMD_EN_DQS,
    CMD_SEND_DB,
    CMD_ALIGN_WPST,
    // CS held low, waiting for command completion
    WAIT_NEW_CMD,
    // Write burst
    WR_WAIT_CL,
    WR_EN_DQS,
    WR_MASK,
    WR_DATA,
    WR_ALIGN_WPST
  } rpc_state_e;

  // DB bus output mux select
  typedef enum logic [1:0] {
    SRC_CMD  = 2'b00,
    SRC_DATA = 2'b01,
    SRC_MASK = 2'b10
  } rpc_db_src_e;

endpackage

`default_nettype wire

// File: rtl/rpc_settings.svh
// RPC DRAM PHY command timing build-time counts and command field layout
`ifndef RPC_SETTINGS_SVH
`define RPC_SETTINGS_SVH

// Command word layout
`define RPC_CMD_WIDTH     32
`define RPC_OPC_LSB       0
`define RPC_OPC_WIDTH     4
// Burst field holds number of words minus one
`define RPC_BL_LSB        21
`define RPC_BL_WIDTH      6

// Sequencer wait counter
`define RPC_CNT_WIDTH     10

// Parallel packet timing, in controller clock cycles
`define RPC_N_CS_SU_HO    2
`define RPC_N_WPST        2
`define RPC_N_RCD         8
`define RPC_N_PRE         6
`define RPC_N_MOD         10
`define RPC_N_WR_WAIT_CL  4
`define RPC_N_WR_WPST     2
`define RPC_N_WR_BESL     5

// Eight-cycle tPPD grid
`define RPC_TPPD_WIDTH    3

`endif
